// File: verilog/core_pkg.sv
`default_nettype none

package core_pkg;

    localparam logic [31:0] RESET_PC = 32'h0000_0000;
    localparam int NUM_REGS = 32;

    typedef logic [NUM_REGS-1:0][31:0] regfile_t;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_PC4
    } wb_sel_e;

    typedef enum logic [1:0] {
        F_IDLE,
        F_REQ,
        F_WAIT,
        F_DISCARD
    } fetch_state_e;

    // ******************************
    // pipeline words
    // ******************************

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] inst;
    } if_id_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        alu_op_e     alu_op;
        logic [31:0] op1;
        logic [31:0] op2;
        logic [31:0] rs2_data;
        logic [31:0] imm;
        logic [4:0]  rd;
        logic        rf_wen;
        wb_sel_e     wb_sel;
        logic        mem_read;
        logic        mem_write;
        logic        branch;
        logic        branch_ne;
        logic        jump;
        logic        ecall;
    } id_ex_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] alu_out;
        logic [31:0] rs2_data;
        logic [31:0] pc4;
        logic [4:0]  rd;
        logic        rf_wen;
        wb_sel_e     wb_sel;
        logic        mem_read;
        logic        mem_write;
        logic        ecall;
    } ex_mem_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] wdata;
        logic [4:0]  rd;
        logic        rf_wen;
        logic        ecall;
    } mem_wb_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] target;
    } redirect_t;

    // ******************************
    // bus words
    // ******************************

    typedef struct packed {
        logic        start;
        logic [31:0] addr;
    } imem_req_t;

    typedef struct packed {
        logic        ready;
        logic        valid;
        logic [31:0] inst;
    } imem_rsp_t;

    typedef struct packed {
        logic        start;
        logic        write;
        logic [31:0] addr;
        logic [31:0] wdata;
    } dmem_req_t;

    typedef struct packed {
        logic        ready;
        logic        rdata_valid;
        logic [31:0] rdata;
    } dmem_rsp_t;

endpackage

`default_nettype wire

// File: verilog/fetch_stage.sv
`default_nettype none

module fetch_stage (
    input  wire logic                clk,
    input  wire logic                reset,
    input  wire core_pkg::redirect_t redirect,
    input  wire logic                hold,
    output core_pkg::imem_req_t      imem_req,
    input  wire core_pkg::imem_rsp_t imem_rsp,
    output core_pkg::if_id_t         if_id
);

    core_pkg::fetch_state_e state;
    logic [31:0] pc;
    logic [31:0] held_inst;
    logic        in_flight;

    assign imem_req.start = (state == core_pkg::F_REQ);
    assign imem_req.addr  = pc;

    // a response is still owed after this cycle
    assign in_flight = (state == core_pkg::F_REQ && imem_rsp.ready) ||
                       ((state == core_pkg::F_WAIT || state == core_pkg::F_DISCARD) &&
                        !imem_rsp.valid);

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= core_pkg::F_REQ;
            pc          <= core_pkg::RESET_PC;
            if_id.valid <= 1'b0;
        end else if (redirect.valid) begin
            pc          <= redirect.target;
            if_id.valid <= 1'b0;
            state       <= in_flight ? core_pkg::F_DISCARD : core_pkg::F_REQ;
        end else begin
            if (!hold)
                if_id.valid <= 1'b0;
            case (state)
                core_pkg::F_REQ:
                    if (imem_rsp.ready)
                        state <= core_pkg::F_WAIT;
                core_pkg::F_WAIT:
                    if (imem_rsp.valid) begin
                        if (hold) begin
                            // decode busy, park the word
                            held_inst <= imem_rsp.inst;
                            state     <= core_pkg::F_IDLE;
                        end else begin
                            if_id <= '{1'b1, pc, imem_rsp.inst};
                            pc    <= pc + 32'd4;
                            state <= core_pkg::F_REQ;
                        end
                    end
                core_pkg::F_IDLE:
                    if (!hold) begin
                        if_id <= '{1'b1, pc, held_inst};
                        pc    <= pc + 32'd4;
                        state <= core_pkg::F_REQ;
                    end
                core_pkg::F_DISCARD:
                    if (imem_rsp.valid)
                        state <= core_pkg::F_REQ;
                default:
                    state <= core_pkg::F_REQ;
            endcase
        end
    end

    // nothing outstanding while parked
    a_no_rsp_idle: assert property (@(posedge clk) disable iff (reset)
        state == core_pkg::F_IDLE |-> !imem_rsp.valid);

endmodule

`default_nettype wire

// File: verilog/decode_stage.sv
`default_nettype none

module decode_stage (
    input  wire logic                clk,
    input  wire logic                reset,
    input  wire core_pkg::if_id_t    if_id,
    input  wire core_pkg::regfile_t  regfile,
    input  wire core_pkg::redirect_t redirect,
    input  wire logic                mem_stall,
    input  wire core_pkg::ex_mem_t   ex_dst,
    input  wire core_pkg::mem_wb_t   wb_dst,
    output core_pkg::id_ex_t         id_ex,
    output logic                     id_stall
);

    core_pkg::opcode_e opcode;
    core_pkg::id_ex_t  dec;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;
    logic        uses_rs1;
    logic        uses_rs2;
    logic        hazard;
    logic        halted;

    function automatic logic hit(input logic [4:0] rs, input logic v, input logic wen,
                                 input logic [4:0] dst);
        return v && wen && rs != 5'd0 && dst == rs;
    endfunction

    assign opcode = core_pkg::opcode_e'(if_id.inst[6:0]);
    assign rd     = if_id.inst[11:7];
    assign funct3 = if_id.inst[14:12];
    assign rs1    = if_id.inst[19:15];
    assign rs2    = if_id.inst[24:20];
    assign funct7 = if_id.inst[31:25];

    assign imm_i = {{20{if_id.inst[31]}}, if_id.inst[31:20]};
    assign imm_s = {{20{if_id.inst[31]}}, if_id.inst[31:25], if_id.inst[11:7]};
    assign imm_b = {{19{if_id.inst[31]}}, if_id.inst[31], if_id.inst[7],
                    if_id.inst[30:25], if_id.inst[11:8], 1'b0};
    assign imm_u = {if_id.inst[31:12], 12'd0};
    assign imm_j = {{11{if_id.inst[31]}}, if_id.inst[31], if_id.inst[19:12],
                    if_id.inst[20], if_id.inst[30:21], 1'b0};

    assign rs1_data = (rs1 == 5'd0) ? 32'd0 : regfile[rs1];
    assign rs2_data = (rs2 == 5'd0) ? 32'd0 : regfile[rs2];

    // ******************************
    // hazard check, no forwarding
    // ******************************
    assign uses_rs1 = opcode inside {core_pkg::OP, core_pkg::OP_IMM, core_pkg::LOAD,
                                     core_pkg::STORE, core_pkg::BRANCH};
    assign uses_rs2 = opcode inside {core_pkg::OP, core_pkg::STORE, core_pkg::BRANCH};

    assign hazard = if_id.valid && (
        (uses_rs1 && (hit(rs1, id_ex.valid, id_ex.rf_wen, id_ex.rd) ||
                      hit(rs1, ex_dst.valid, ex_dst.rf_wen, ex_dst.rd) ||
                      hit(rs1, wb_dst.valid, wb_dst.rf_wen, wb_dst.rd))) ||
        (uses_rs2 && (hit(rs2, id_ex.valid, id_ex.rf_wen, id_ex.rd) ||
                      hit(rs2, ex_dst.valid, ex_dst.rf_wen, ex_dst.rd) ||
                      hit(rs2, wb_dst.valid, wb_dst.rf_wen, wb_dst.rd))));

    assign id_stall = hazard || halted;

    always_comb begin
        dec          = '0;
        dec.pc       = if_id.pc;
        dec.op1      = rs1_data;
        dec.op2      = rs2_data;
        dec.rs2_data = rs2_data;
        dec.rd       = rd;
        dec.alu_op   = core_pkg::ALU_ADD;
        dec.wb_sel   = core_pkg::WB_ALU;
        case (opcode)
            core_pkg::OP: begin
                dec.rf_wen = 1'b1;
                case (funct3)
                    3'b000:  dec.alu_op = funct7[5] ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
                    3'b010:  dec.alu_op = core_pkg::ALU_SLT;
                    3'b100:  dec.alu_op = core_pkg::ALU_XOR;
                    3'b110:  dec.alu_op = core_pkg::ALU_OR;
                    3'b111:  dec.alu_op = core_pkg::ALU_AND;
                    default: dec.alu_op = core_pkg::ALU_ADD;
                endcase
            end
            core_pkg::OP_IMM: begin
                dec.op2    = imm_i;
                dec.rf_wen = 1'b1;
            end
            core_pkg::LUI: begin
                dec.op2    = imm_u;
                dec.alu_op = core_pkg::ALU_PASS_B;
                dec.rf_wen = 1'b1;
            end
            core_pkg::LOAD: begin
                dec.op2      = imm_i;
                dec.rf_wen   = 1'b1;
                dec.mem_read = 1'b1;
                dec.wb_sel   = core_pkg::WB_MEM;
            end
            core_pkg::STORE: begin
                dec.op2       = imm_s;
                dec.mem_write = 1'b1;
            end
            core_pkg::BRANCH: begin
                dec.imm       = imm_b;
                dec.branch    = 1'b1;
                dec.branch_ne = funct3[0];
            end
            core_pkg::JAL: begin
                dec.imm    = imm_j;
                dec.jump   = 1'b1;
                dec.rf_wen = 1'b1;
                dec.wb_sel = core_pkg::WB_PC4;
            end
            core_pkg::SYSTEM: dec.ecall = 1'b1;
            default: ;
        endcase
        // bubble on stall or flush
        dec.valid = if_id.valid && !id_stall && !redirect.valid;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            id_ex.valid <= 1'b0;
            halted      <= 1'b0;
        end else if (!mem_stall) begin
            id_ex <= dec;
            if (dec.valid && dec.ecall)
                halted <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: verilog/execute_stage.sv
`default_nettype none

module execute_stage (
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire core_pkg::id_ex_t  id_ex,
    input  wire logic              mem_stall,
    output core_pkg::ex_mem_t      ex_mem,
    output core_pkg::redirect_t    redirect
);

    logic [31:0] alu_out;
    logic        equal;
    logic        taken;

    always_comb begin
        case (id_ex.alu_op)
            core_pkg::ALU_ADD:    alu_out = id_ex.op1 + id_ex.op2;
            core_pkg::ALU_SUB:    alu_out = id_ex.op1 - id_ex.op2;
            core_pkg::ALU_AND:    alu_out = id_ex.op1 & id_ex.op2;
            core_pkg::ALU_OR:     alu_out = id_ex.op1 | id_ex.op2;
            core_pkg::ALU_XOR:    alu_out = id_ex.op1 ^ id_ex.op2;
            core_pkg::ALU_SLT:    alu_out = {31'd0, $signed(id_ex.op1) < $signed(id_ex.op2)};
            core_pkg::ALU_PASS_B: alu_out = id_ex.op2;
            default:              alu_out = 32'd0;
        endcase
    end

    // beq/bne share one compare
    assign equal = (id_ex.op1 == id_ex.op2);
    assign taken = id_ex.valid &&
                   ((id_ex.branch && (equal ^ id_ex.branch_ne)) || id_ex.jump);

    // one cycle only, the branch leaves execute at the same edge
    assign redirect.valid  = taken && !mem_stall;
    assign redirect.target = id_ex.pc + id_ex.imm;

    always_ff @(posedge clk) begin
        if (reset) begin
            ex_mem.valid <= 1'b0;
        end else if (!mem_stall) begin
            ex_mem.valid     <= id_ex.valid;
            ex_mem.alu_out   <= alu_out;
            ex_mem.rs2_data  <= id_ex.rs2_data;
            ex_mem.pc4       <= id_ex.pc + 32'd4;
            ex_mem.rd        <= id_ex.rd;
            ex_mem.rf_wen    <= id_ex.rf_wen;
            ex_mem.wb_sel    <= id_ex.wb_sel;
            ex_mem.mem_read  <= id_ex.mem_read;
            ex_mem.mem_write <= id_ex.mem_write;
            ex_mem.ecall     <= id_ex.ecall;
        end
    end

endmodule

`default_nettype wire

// File: verilog/memory_stage.sv
`default_nettype none

module memory_stage (
    input  wire logic                clk,
    input  wire logic                reset,
    input  wire core_pkg::ex_mem_t   ex_mem,
    output core_pkg::dmem_req_t      dmem_req,
    input  wire core_pkg::dmem_rsp_t dmem_rsp,
    output core_pkg::mem_wb_t        mem_wb,
    output logic                     mem_stall
);

    logic        access;
    logic        accepted;
    logic        done;
    logic [31:0] wb_data;

    assign access = ex_mem.valid && (ex_mem.mem_read || ex_mem.mem_write);

    assign dmem_req.start = access && !accepted;
    assign dmem_req.write = ex_mem.mem_write;
    assign dmem_req.addr  = {ex_mem.alu_out[31:2], 2'b00};
    assign dmem_req.wdata = ex_mem.rs2_data;

    // store ends on acceptance, load on its data
    assign done      = ex_mem.mem_write ? dmem_rsp.ready
                                        : (accepted && dmem_rsp.rdata_valid);
    assign mem_stall = access && !done;

    always_ff @(posedge clk) begin
        if (reset)
            accepted <= 1'b0;
        else if (accepted && dmem_rsp.rdata_valid)
            accepted <= 1'b0;
        else if (dmem_req.start && dmem_rsp.ready && !ex_mem.mem_write)
            accepted <= 1'b1;
    end

    always_comb begin
        case (ex_mem.wb_sel)
            core_pkg::WB_MEM: wb_data = dmem_rsp.rdata;
            core_pkg::WB_PC4: wb_data = ex_mem.pc4;
            default:          wb_data = ex_mem.alu_out;
        endcase
    end

    // a bubble goes on while this stage waits
    always_ff @(posedge clk) begin
        if (reset) begin
            mem_wb.valid <= 1'b0;
        end else begin
            mem_wb.valid  <= ex_mem.valid && !mem_stall;
            mem_wb.wdata  <= wb_data;
            mem_wb.rd     <= ex_mem.rd;
            mem_wb.rf_wen <= ex_mem.rf_wen;
            mem_wb.ecall  <= ex_mem.ecall;
        end
    end

    a_req_steady: assert property (@(posedge clk) disable iff (reset)
        dmem_req.start && !dmem_rsp.ready |=> dmem_req.start && $stable(dmem_req));

endmodule

`default_nettype wire

// File: verilog/writeback_stage.sv
`default_nettype none

module writeback_stage (
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire core_pkg::mem_wb_t mem_wb,
    output core_pkg::regfile_t     regfile,
    output logic                   exit,
    output logic [31:0]            gp
);

    assign gp = regfile[3];

    always_ff @(posedge clk) begin
        if (reset)
            regfile <= '0;
        else if (mem_wb.valid && mem_wb.rf_wen && mem_wb.rd != 5'd0)
            regfile[mem_wb.rd] <= mem_wb.wdata;
    end

    // sticky until reset
    always_ff @(posedge clk) begin
        if (reset)
            exit <= 1'b0;
        else if (mem_wb.valid && mem_wb.ecall)
            exit <= 1'b1;
    end

    // nothing retires once exit is up
    a_no_retire_after_exit: assert property (@(posedge clk) disable iff (reset)
        exit |-> !mem_wb.valid);

endmodule

`default_nettype wire

// File: verilog/core.sv
`default_nettype none

module core (
    input  wire logic                clk,
    input  wire logic                reset,
    output core_pkg::imem_req_t      imem_req,
    input  wire core_pkg::imem_rsp_t imem_rsp,
    output core_pkg::dmem_req_t      dmem_req,
    input  wire core_pkg::dmem_rsp_t dmem_rsp,
    output logic                     exit,
    output logic [31:0]              gp
);

    core_pkg::if_id_t    if_id;
    core_pkg::id_ex_t    id_ex;
    core_pkg::ex_mem_t   ex_mem;
    core_pkg::mem_wb_t   mem_wb;
    core_pkg::redirect_t redirect;
    core_pkg::regfile_t  regfile;
    logic                mem_stall;
    logic                id_stall;
    logic                fetch_hold;

    assign fetch_hold = id_stall || mem_stall;

    // ******************************
    // front end
    // ******************************
    fetch_stage u_fetch (
        .clk      (clk),
        .reset    (reset),
        .redirect (redirect),
        .hold     (fetch_hold),
        .imem_req (imem_req),
        .imem_rsp (imem_rsp),
        .if_id    (if_id)
    );

    decode_stage u_decode (
        .clk       (clk),
        .reset     (reset),
        .if_id     (if_id),
        .regfile   (regfile),
        .redirect  (redirect),
        .mem_stall (mem_stall),
        .ex_dst    (ex_mem),
        .wb_dst    (mem_wb),
        .id_ex     (id_ex),
        .id_stall  (id_stall)
    );

    // ******************************
    // back end
    // ******************************
    execute_stage u_execute (
        .clk       (clk),
        .reset     (reset),
        .id_ex     (id_ex),
        .mem_stall (mem_stall),
        .ex_mem    (ex_mem),
        .redirect  (redirect)
    );

    memory_stage u_memory (
        .clk       (clk),
        .reset     (reset),
        .ex_mem    (ex_mem),
        .dmem_req  (dmem_req),
        .dmem_rsp  (dmem_rsp),
        .mem_wb    (mem_wb),
        .mem_stall (mem_stall)
    );

    writeback_stage u_writeback (
        .clk     (clk),
        .reset   (reset),
        .mem_wb  (mem_wb),
        .regfile (regfile),
        .exit    (exit),
        .gp      (gp)
    );

endmodule

`default_nettype wire

// File: tb/tb_memory.sv
`default_nettype none

module tb_memory (
    input  wire logic                clk,
    input  wire logic                reset,
    input  wire logic [31:0]         fill_seed,
    input  wire core_pkg::imem_req_t imem_req,
    output core_pkg::imem_rsp_t      imem_rsp,
    input  wire core_pkg::dmem_req_t dmem_req,
    output core_pkg::dmem_rsp_t      dmem_rsp
);
    timeunit 1ns;
    timeprecision 1ps;

    // program words, loaded by the testbench top
    logic [31:0] rom [256];
    logic [31:0] ram [1024];

    logic        i_busy;
    logic [1:0]  i_cnt;
    logic [31:0] i_addr;
    logic        d_busy;
    logic [1:0]  d_cnt;
    logic [31:0] d_addr;

    initial begin
        imem_rsp = '0;
        dmem_rsp = '0;
    end

    // ******************************
    // instruction side
    // ******************************
    always @(posedge clk) begin
        if (reset) begin
            imem_rsp <= '0;
            i_busy   <= 1'b0;
            i_cnt    <= 2'd0;
        end else begin
            imem_rsp.ready <= ($urandom % 4) != 0;
            imem_rsp.valid <= 1'b0;
            if (i_busy) begin
                if (i_cnt == 2'd0) begin
                    imem_rsp.valid <= 1'b1;
                    imem_rsp.inst  <= rom[i_addr[9:2]];
                    i_busy         <= 1'b0;
                end else begin
                    i_cnt <= i_cnt - 2'd1;
                end
            end else if (imem_req.start && imem_rsp.ready) begin
                i_busy <= 1'b1;
                i_addr <= imem_req.addr;
                i_cnt  <= 2'($urandom % 3);
            end
        end
    end

    // ******************************
    // data side
    // ******************************
    always @(posedge clk) begin
        if (reset) begin
            dmem_rsp <= '0;
            d_busy   <= 1'b0;
            d_cnt    <= 2'd0;
            // pattern mixes every address bit
            for (int j = 0; j < 1024; j++)
                ram[j] <= fill_seed ^ (32'(j) * 32'h9E37_79B9) ^ (32'(j) << 22);
        end else begin
            dmem_rsp.ready       <= ($urandom % 4) != 0;
            dmem_rsp.rdata_valid <= 1'b0;
            if (d_busy) begin
                if (d_cnt == 2'd0) begin
                    dmem_rsp.rdata_valid <= 1'b1;
                    dmem_rsp.rdata       <= ram[d_addr[11:2]];
                    d_busy               <= 1'b0;
                end else begin
                    d_cnt <= d_cnt - 2'd1;
                end
            end else if (dmem_req.start && dmem_rsp.ready) begin
                if (dmem_req.write) begin
                    ram[dmem_req.addr[11:2]] <= dmem_req.wdata;
                end else begin
                    d_busy <= 1'b1;
                    d_addr <= dmem_req.addr;
                    d_cnt  <= 2'($urandom % 3);
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: tb/tb_core.sv
`default_nettype none

module tb_core;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_PROGS = 20;
    localparam int PROG_LEN = 64;
    localparam longint LIMIT_NS = longint'(NUM_PROGS) * PROG_LEN * 40 * 20;
    localparam logic [31:0] ECALL_WORD = 32'h0000_0073;

    logic                clk;
    logic                reset;
    logic [31:0]         fill_seed;
    core_pkg::imem_req_t imem_req;
    core_pkg::imem_rsp_t imem_rsp;
    core_pkg::dmem_req_t dmem_req;
    core_pkg::dmem_rsp_t dmem_rsp;
    logic                exit;
    logic [31:0]         gp;

    int                  errors;
    logic                seen_exit;
    logic [31:0]         prog [PROG_LEN];
    logic [31:0]         model_regs [32];
    logic [31:0]         model_ram [1024];
    logic [31:0]         exp_gp;
    logic [4:0]          recent [3];
    core_pkg::dmem_req_t exp_stores [$];

    core uut (
        .clk      (clk),
        .reset    (reset),
        .imem_req (imem_req),
        .imem_rsp (imem_rsp),
        .dmem_req (dmem_req),
        .dmem_rsp (dmem_rsp),
        .exit     (exit),
        .gp       (gp)
    );

    tb_memory mem (
        .clk       (clk),
        .reset     (reset),
        .fill_seed (fill_seed),
        .imem_req  (imem_req),
        .imem_rsp  (imem_rsp),
        .dmem_req  (dmem_req),
        .dmem_rsp  (dmem_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        #(LIMIT_NS);
        $display("Timeout: the core never finished all programs");
        $display("Finished with errors");
        $finish;
    end

    // ******************************
    // instruction encoders
    // ******************************
    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic logic [31:0] enc_i(input logic [6:0] op, input logic [4:0] rd,
                                          input logic [4:0] rs1, input logic [11:0] imm);
        return {imm, rs1, 3'b010 & {3{op == 7'h03}}, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(input logic [4:0] rs1, input logic [4:0] rs2,
                                          input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] enc_b(input logic [2:0] f3, input logic [4:0] rs1,
                                          input logic [4:0] rs2, input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] enc_j(input logic [4:0] rd, input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
    endfunction

    // half the sources come from recent destinations
    function automatic logic [4:0] pick_src();
        if ($urandom % 2)
            return recent[$urandom % 3];
        return 5'($urandom % 8);
    endfunction

    task automatic gen_program();
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        int         kind;
        int         left;
        int         k;
        logic [2:0] f3;
        for (int i = 0; i < PROG_LEN - 1; i++) begin
            kind = $urandom % 100;
            rd   = 5'(1 + $urandom % 7);
            rs1  = pick_src();
            rs2  = pick_src();
            left = PROG_LEN - 1 - i;
            k    = 1 + $urandom % ((left < 6) ? left : 6);
            if (kind < 30) begin
                case ($urandom % 6)
                    0:       prog[i] = enc_r(7'h00, 3'b000, rd, rs1, rs2);
                    1:       prog[i] = enc_r(7'h20, 3'b000, rd, rs1, rs2);
                    2:       prog[i] = enc_r(7'h00, 3'b010, rd, rs1, rs2);
                    3:       prog[i] = enc_r(7'h00, 3'b100, rd, rs1, rs2);
                    4:       prog[i] = enc_r(7'h00, 3'b110, rd, rs1, rs2);
                    default: prog[i] = enc_r(7'h00, 3'b111, rd, rs1, rs2);
                endcase
            end else if (kind < 45) begin
                prog[i] = enc_i(7'h13, rd, rs1, 12'($urandom));
            end else if (kind < 53) begin
                prog[i] = {20'($urandom), rd, 7'h37};
            end else if (kind < 65) begin
                prog[i] = enc_i(7'h03, rd, rs1, 12'($urandom));
            end else if (kind < 80) begin
                prog[i] = enc_s(rs1, rs2, 12'($urandom));
            end else if (kind < 92) begin
                f3 = ($urandom % 2) ? 3'b001 : 3'b000;
                prog[i] = enc_b(f3, rs1, rs2, 13'(4 * k));
            end else begin
                prog[i] = enc_j(rd, 21'(4 * k));
            end
            if (kind < 65 || kind >= 92) begin
                recent[2] = recent[1];
                recent[1] = recent[0];
                recent[0] = rd;
            end
        end
        prog[PROG_LEN-1] = ECALL_WORD;
    endtask

    // ******************************
    // instruction-set model
    // ******************************
    task automatic run_model();
        logic [31:0]         pc;
        logic [31:0]         w;
        logic [31:0]         a;
        logic [31:0]         b;
        logic [31:0]         res;
        logic [31:0]         imm;
        logic [31:0]         addr;
        logic                wr;
        logic                done;
        int                  steps;
        core_pkg::dmem_req_t st;
        for (int r = 0; r < 32; r++)
            model_regs[r] = 32'd0;
        exp_stores.delete();
        pc    = 32'd0;
        done  = 1'b0;
        steps = 0;
        while (!done && steps < 1000) begin
            w     = prog[pc[7:2]];
            a     = model_regs[w[19:15]];
            b     = model_regs[w[24:20]];
            res   = 32'd0;
            wr    = 1'b0;
            steps = steps + 1;
            case (w[6:0])
                7'h33: begin
                    wr = 1'b1;
                    case (w[14:12])
                        3'b000:  res = w[30] ? a - b : a + b;
                        3'b010:  res = {31'd0, $signed(a) < $signed(b)};
                        3'b100:  res = a ^ b;
                        3'b110:  res = a | b;
                        default: res = a & b;
                    endcase
                    pc = pc + 4;
                end
                7'h13: begin
                    res = a + {{20{w[31]}}, w[31:20]};
                    wr  = 1'b1;
                    pc  = pc + 4;
                end
                7'h37: begin
                    res = {w[31:12], 12'd0};
                    wr  = 1'b1;
                    pc  = pc + 4;
                end
                7'h03: begin
                    addr = a + {{20{w[31]}}, w[31:20]};
                    res  = model_ram[addr[11:2]];
                    wr   = 1'b1;
                    pc   = pc + 4;
                end
                7'h23: begin
                    addr     = a + {{20{w[31]}}, w[31:25], w[11:7]};
                    st.start = 1'b1;
                    st.write = 1'b1;
                    st.addr  = {addr[31:2], 2'b00};
                    st.wdata = b;
                    exp_stores.push_back(st);
                    model_ram[addr[11:2]] = b;
                    pc = pc + 4;
                end
                7'h63: begin
                    imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
                    pc  = (((a == b) ^ w[12]) != 1'b0) ? pc + imm : pc + 4;
                end
                7'h6f: begin
                    imm = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
                    res = pc + 4;
                    wr  = 1'b1;
                    pc  = pc + imm;
                end
                default: done = 1'b1;
            endcase
            if (wr && w[11:7] != 5'd0)
                model_regs[w[11:7]] = res;
        end
        exp_gp = model_regs[3];
    endtask

    // ******************************
    // checks
    // ******************************
    task automatic check_store(input core_pkg::dmem_req_t got, input core_pkg::dmem_req_t exp);
        if (got.addr !== exp.addr || got.wdata !== exp.wdata) begin
            errors = errors + 1;
            $display("Error at %0t: store %h <= %h, expected %h <= %h", $time,
                     got.addr, got.wdata, exp.addr, exp.wdata);
        end
    endtask

    task automatic check_gp(input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors = errors + 1;
            $display("Error at %0t: gp is %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic check_fetch(input core_pkg::imem_req_t got, input core_pkg::imem_req_t exp);
        if (got !== exp) begin
            errors = errors + 1;
            $display("Error at %0t: fetch start %b at %h, expected start %b at %h", $time,
                     got.start, got.addr, exp.start, exp.addr);
        end
    endtask

    task automatic check_quiet();
        if (exit !== 1'b0 || dmem_req.start !== 1'b0) begin
            errors = errors + 1;
            $display("Error at %0t: exit %b, data start %b in reset", $time,
                     exit, dmem_req.start);
        end
    endtask

    // one sampled cycle of the running program
    task automatic watch_bus();
        if (seen_exit && exit !== 1'b1) begin
            errors = errors + 1;
            $display("Exit dropped after it had risen at %0t", $time);
        end
        if (exit === 1'b1)
            seen_exit = 1'b1;
        if (dmem_req.start && dmem_rsp.ready && dmem_req.write) begin
            if (seen_exit) begin
                errors = errors + 1;
                $display("A store reached the bus after exit at %0t", $time);
            end else if (exp_stores.size() == 0) begin
                errors = errors + 1;
                $display("An extra store reached the bus at %0t", $time);
            end else begin
                check_store(dmem_req, exp_stores.pop_front());
            end
        end
    endtask

    initial begin
        int                  post;
        core_pkg::imem_req_t first_fetch;
        reset     = 1'b1;
        fill_seed = 32'd0;
        errors    = 0;
        // first request after reset goes to address zero
        first_fetch.start = 1'b1;
        first_fetch.addr  = 32'h0000_0000;
        void'($urandom(50931));
        for (int p = 0; p < NUM_PROGS; p++) begin
            recent[0] = 5'd1;
            recent[1] = 5'd2;
            recent[2] = 5'd3;
            gen_program();
            @(posedge clk);
            reset     <= 1'b1;
            fill_seed <= $urandom;
            for (int i = 0; i < 256; i++)
                mem.rom[i] = (i < PROG_LEN) ? prog[i] : ECALL_WORD;
            for (int c = 0; c < 8; c++) begin
                @(posedge clk);
                if (c > 0)
                    check_quiet();
            end
            for (int j = 0; j < 1024; j++)
                model_ram[j] = mem.ram[j];
            run_model();
            reset <= 1'b0;
            @(posedge clk);
            check_quiet();
            check_fetch(imem_req, first_fetch);
            seen_exit = 1'b0;
            post      = 0;
            while (post < 20) begin
                @(posedge clk);
                watch_bus();
                if (seen_exit)
                    post = post + 1;
            end
            check_gp(gp, exp_gp);
            if (exp_stores.size() != 0) begin
                errors = errors + 1;
                $display("Program %0d ended with %0d expected stores missing", p,
                         exp_stores.size());
            end
        end
        $display("errors: %0d", errors);
        if (errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
verilog/core_pkg.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/memory_stage.sv
verilog/writeback_stage.sv
verilog/core.sv
tb/tb_memory.sv
tb/tb_core.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module tb_core \
    -Mdir obj_dir -o tb_core_sim

./obj_dir/tb_core_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Finished with errors" sim.log; then
    echo "simulation failed"
    exit 1
fi
if ! grep -q "Finished with no errors" sim.log; then
    echo "simulation did not complete"
    exit 1
fi
echo "simulation passed"
